// File: fetch_pkg.sv
package fetch_pkg;

	// widths with a meaning of their own
	typedef logic [31:0] addr_t;	// byte address of a fetch
	typedef logic [31:0] instr_t;
	typedef logic [63:0] line_t;	// one half of a 128-bit fill
	typedef logic [3:0]  rtype_t;	// l1.5 return type field

	// pc select code from decode
	typedef enum logic [1:0]
	{
		PC_SEQ    = 2'b00,
		PC_RESET  = 2'b01,
		PC_TARGET = 2'b10,
		PC_HOLD   = 2'b11
	} pcsel_t;

	// l1.5 return types this front end knows about
	localparam rtype_t RT_LOAD   = 4'b0000;
	localparam rtype_t RT_IFILL  = 4'b0001;
	localparam rtype_t RT_ST_ACK = 4'b0100;
	localparam rtype_t RT_INT    = 4'b0111;	// interrupt return, wakes the core

	// boot address
	localparam addr_t RESET_VECTOR = 32'h40000000;

	// add x0, x0, x0
	localparam instr_t NOP_INSTR = 32'h00000033;

	// request FSM
	typedef enum logic [1:0]
	{
		S_REQ,		// val up, waiting for header_ack
		S_WAIT_ACK,	// header taken, waiting for ack
		S_RESP		// waiting for the ifill return
	} fetch_state_t;

endpackage

// File: fetch_pc_gen.sv
module fetch_pc_gen import fetch_pkg::*;
#(
	parameter addr_t RESET_PC = RESET_VECTOR
)
(
	input  logic   clk,
	input  logic   nrst,
	input  logic   stall,
	input  logic   exception_pending,
	input  pcsel_t pcsel,
	input  addr_t  target,
	input  addr_t  epc,
	input  logic   fetch_done,
	input  logic   delivered,
	output addr_t  fetch_pc,
	output addr_t  pc2,
	output logic   redirect,
	output logic   addr_misaligned
);

	addr_t pc_q;		// pc of the fetch in flight
	addr_t last_pc_q;	// pc of the last delivered word
	addr_t pend_pc_q;	// redirect target waiting for the fetch to end
	logic  pend_q;
	addr_t redir_pc;

	// a redirect is only taken while decode is not stalled
	assign redirect = !stall &&
		(exception_pending || pcsel == PC_TARGET || pcsel == PC_RESET);

	// exception wins over any pc select
	always_comb
	begin
		if (exception_pending)
			redir_pc = epc;
		else if (pcsel == PC_TARGET)
			redir_pc = target;
		else
			redir_pc = RESET_PC;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pc_q      <= RESET_PC;
			last_pc_q <= RESET_PC;
			pend_q    <= 1'b0;
		end
		else
		begin
			if (fetch_done)
			begin
				pend_q <= 1'b0;
				if (redirect)
					pc_q <= redir_pc;	// redirect in the last cycle of a fetch
				else if (pend_q)
					pc_q <= pend_pc_q;
				else if (delivered)
					pc_q <= pc_q + 32'd4;
				// otherwise the word was dropped by a stall, fetch it again
			end
			else if (redirect)
			begin
				pend_q <= 1'b1;
			end

			if (delivered)
				last_pc_q <= pc_q;
		end
	end

	// target only, its valid bit lives above
	always_ff @(posedge clk)
	begin
		if (redirect && !fetch_done)
			pend_pc_q <= redir_pc;	// a later redirect overwrites an older one
	end

	assign fetch_pc = pc_q;

	// decode sees the delivered pc, otherwise the last one it got
	assign pc2 = delivered ? pc_q : last_pc_q;

	assign addr_misaligned = delivered && pc_q[1] && pc_q[0];

endmodule

// File: fetch_l15_port.sv
module fetch_l15_port import fetch_pkg::*;
(
	input  logic       clk,
	input  logic       nrst,
	input  logic       stall,
	input  logic       redirect,
	input  addr_t      fetch_pc,
	output logic [4:0] l15_rqtype,
	output logic [2:0] l15_size,
	output addr_t      l15_address,
	output logic       l15_val,
	output logic       l15_req_ack,
	input  logic       l15_header_ack,
	input  logic       l15_ack,
	input  logic       l15_resp_val,
	input  line_t      l15_data_0,
	input  line_t      l15_data_1,
	input  rtype_t     l15_returntype,
	output instr_t     instr2,
	output logic       instr_valid,
	output logic       fetch_done
);

	localparam logic [4:0] IFETCH_RQTYPE = 5'b00000;
	localparam logic [2:0] IFETCH_SIZE   = 3'b010;	// one 4-byte word

	fetch_state_t state_q;
	fetch_state_t state_d;

	logic   awake;		// set by the first interrupt return
	logic   req_hold_q;	// val is up and not yet taken
	logic   stale_q;	// fetch in flight is no longer wanted
	logic   req_accept;
	logic   ifill_resp;
	logic   in_flight;
	logic   discard;
	instr_t word;

	// sleep until an interrupt return shows up
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			awake <= 1'b0;
		else if (!awake && l15_resp_val && l15_returntype == RT_INT)
			awake <= 1'b1;
	end

	// stall blocks a new request, but a raised val stays up until taken
	assign l15_val = awake && state_q == S_REQ && (req_hold_q || !stall);

	assign req_accept = l15_val && l15_header_ack;
	assign ifill_resp = l15_resp_val && l15_returntype == RT_IFILL;
	assign fetch_done = state_q == S_RESP && ifill_resp;

	// other return types are acked and dropped in any state
	assign l15_req_ack = l15_resp_val && (state_q == S_RESP || l15_returntype != RT_IFILL);

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			S_REQ:
			begin
				if (req_accept)
					state_d = l15_ack ? S_RESP : S_WAIT_ACK;
			end
			S_WAIT_ACK:
			begin
				if (l15_ack)
					state_d = S_RESP;
			end
			S_RESP:
			begin
				if (ifill_resp)
					state_d = S_REQ;
			end
			default:
			begin
				state_d = S_REQ;
			end
		endcase
	end

	assign in_flight = state_q != S_REQ || l15_val;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			state_q    <= S_REQ;
			req_hold_q <= 1'b0;
			stale_q    <= 1'b0;
		end
		else
		begin
			state_q    <= state_d;
			req_hold_q <= l15_val && !l15_header_ack;

			if (fetch_done)
				stale_q <= 1'b0;
			else if (redirect || (stall && in_flight))
				stale_q <= 1'b1;	// redirect while idle also forces one dropped fetch
		end
	end

	// anything that makes the word wrong in this cycle
	assign discard = stale_q || stall || redirect;

	assign instr_valid = fetch_done && !discard;

	// word select by address bits 3:2, big-endian within the line
	always_comb
	begin
		case (fetch_pc[3:2])
			2'b00:   word = l15_data_0[63:32];
			2'b01:   word = l15_data_0[31:0];
			2'b10:   word = l15_data_1[63:32];
			default: word = l15_data_1[31:0];
		endcase
	end

	// byte swap to little-endian, no-op when nothing goes out
	assign instr2 = instr_valid ? {word[7:0], word[15:8], word[23:16], word[31:24]} : NOP_INSTR;

	assign l15_address = fetch_pc;
	assign l15_rqtype  = IFETCH_RQTYPE;
	assign l15_size    = IFETCH_SIZE;

endmodule

// File: fetch_top.sv
module fetch_top import fetch_pkg::*;
#(
	parameter addr_t RESET_PC = RESET_VECTOR
)
(
	input  logic       clk,
	input  logic       nrst,

	// decode side
	input  logic       stall,
	input  pcsel_t     pcsel,
	input  addr_t      target,
	input  logic       exception_pending,
	input  addr_t      epc,
	output addr_t      pc2,
	output instr_t     instr2,
	output logic       instr_valid,
	output logic       addr_misaligned,

	// l1.5 request
	output logic [4:0] l15_rqtype,
	output logic [2:0] l15_size,
	output addr_t      l15_address,
	output logic       l15_val,
	input  logic       l15_header_ack,
	input  logic       l15_ack,

	// l1.5 response
	input  logic       l15_resp_val,
	input  line_t      l15_data_0,
	input  line_t      l15_data_1,
	input  rtype_t     l15_returntype,
	output logic       l15_req_ack
);

	addr_t fetch_pc;
	logic  redirect;
	logic  fetch_done;

	fetch_pc_gen #(
		.RESET_PC(RESET_PC)
	) pcg0 (
		.clk(clk),
		.nrst(nrst),
		.stall(stall),
		.exception_pending(exception_pending),
		.pcsel(pcsel),
		.target(target),
		.epc(epc),
		.fetch_done(fetch_done),
		.delivered(instr_valid),	// a delivered word is a valid instruction
		.fetch_pc(fetch_pc),
		.pc2(pc2),
		.redirect(redirect),
		.addr_misaligned(addr_misaligned)
	);

	fetch_l15_port l15p0 (
		.clk(clk),
		.nrst(nrst),
		.stall(stall),
		.redirect(redirect),
		.fetch_pc(fetch_pc),
		.l15_rqtype(l15_rqtype),
		.l15_size(l15_size),
		.l15_address(l15_address),
		.l15_val(l15_val),
		.l15_req_ack(l15_req_ack),
		.l15_header_ack(l15_header_ack),
		.l15_ack(l15_ack),
		.l15_resp_val(l15_resp_val),
		.l15_data_0(l15_data_0),
		.l15_data_1(l15_data_1),
		.l15_returntype(l15_returntype),
		.instr2(instr2),
		.instr_valid(instr_valid),
		.fetch_done(fetch_done)
	);

endmodule

// File: fetch_top_properties.sv
module fetch_top_properties import fetch_pkg::*;
(
	input logic         clk,
	input logic         nrst,
	input logic         l15_val,
	input logic         l15_header_ack,
	input addr_t        l15_address,
	input logic         l15_resp_val,
	input rtype_t       l15_returntype,
	input logic         instr_valid,
	input fetch_state_t state
);

	logic int_seen;	// an interrupt return has been on the bus

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			int_seen <= 1'b0;
		else if (l15_resp_val && l15_returntype == RT_INT)
			int_seen <= 1'b1;
	end

	// request stays up with the same address until the header is taken
	a_val_held: assert property (@(posedge clk) disable iff (!nrst)
		l15_val && !l15_header_ack |=> l15_val && $stable(l15_address))
		else $error("l15_val or l15_address changed before header_ack");

	// no request before the interrupt return
	a_asleep: assert property (@(posedge clk) disable iff (!nrst)
		!int_seen |-> !l15_val)
		else $error("l15_val raised before any interrupt return");

	// delivered word comes from S_RESP with the address that was requested
	a_valid_in_resp: assert property (@(posedge clk) disable iff (!nrst)
		instr_valid |-> state == S_RESP && $stable(l15_address))
		else $error("instr_valid outside S_RESP or with a moved address");

endmodule

bind fetch_top fetch_top_properties props0 (
	.clk(clk),
	.nrst(nrst),
	.l15_val(l15_val),
	.l15_header_ack(l15_header_ack),
	.l15_address(l15_address),
	.l15_resp_val(l15_resp_val),
	.l15_returntype(l15_returntype),
	.instr_valid(instr_valid),
	.state(l15p0.state_q)
);

// File: tb_fetch_top.sv
module tb_fetch_top import fetch_pkg::*;
();

	localparam int N_WAKE = 4;
	localparam int N_SEQ = 40;
	localparam int N_REDIR = 40;
	localparam int N_STALL = 40;
	localparam int N_MISC = 24;
	localparam int TIMEOUT_CYCLES = 20 * (N_WAKE + N_SEQ + N_REDIR + N_STALL + N_MISC);

	localparam addr_t BOOT_PC = 32'h00008000;	// differs from the package default
	localparam logic [4:0] RQ_IFETCH = 5'b00000;
	localparam logic [2:0] SZ_4B = 3'b010;

	logic clk = 1'b0;
	logic nrst;
	logic stall;
	pcsel_t pcsel;
	addr_t target;
	logic exception_pending;
	addr_t epc;
	addr_t pc2;
	instr_t instr2;
	logic instr_valid;
	logic addr_misaligned;
	logic [4:0] l15_rqtype;
	logic [2:0] l15_size;
	addr_t l15_address;
	logic l15_val;
	logic l15_header_ack;
	logic l15_ack;
	logic l15_resp_val;
	line_t l15_data_0;
	line_t l15_data_1;
	rtype_t l15_returntype;
	logic l15_req_ack;

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int delivered = 0;
	int misaligned_seen = 0;
	addr_t exp_pc;		// next pc in program order
	addr_t req_addr;	// address the responder accepted
	int rphase = 0;		// responder: 0 header, 1 ack, 2 response
	int hdr_cnt;
	int ack_cnt;
	int resp_cnt;
	int stall_left = 0;
	logic woke = 1'b0;
	logic first_seen = 1'b0;
	logic val_held = 1'b0;
	logic ifill_now = 1'b0;
	logic foreign_now = 1'b0;
	logic int_now = 1'b0;
	logic stall_mode = 1'b0;
	logic redir_mode = 1'b0;
	logic foreign_mode = 1'b0;
	logic misalign_mode = 1'b0;
	logic force_redirect = 1'b0;

	fetch_top #(.RESET_PC(BOOT_PC)) dut0 (.*);

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES)
		begin
			$display("Timeout: only %0d words delivered after %0d cycles", delivered, cycles);
			$display("Errors found");
			$finish;
		end
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("CHECK FAILED at time %0t: %s, got %h expected %h",
				$time, what, actual, expected);
		end
	endtask

	// memory image, every word depends on its full address
	function automatic instr_t word_at(input addr_t a);
		return ({a[31:2], 2'b00} * 32'h9e3779b1) ^ 32'h2c1b3c6d;
	endfunction

	function automatic instr_t swap_bytes(input instr_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	function automatic addr_t rand_target(input logic odd);
		addr_t a;
		a = RESET_VECTOR + ($urandom & 32'h3ffc);
		if (odd)
			a[1:0] = 2'b11;
		return a;
	endfunction

	task automatic drive_cycle();
		logic [2:0] kind;
		addr_t base;
		kind = $urandom;
		stall = 1'b0;
		if (stall_mode && stall_left == 0 && $urandom % 8 == 0)
			stall_left = 1 + $urandom % 8;
		if (stall_left != 0)
		begin
			stall = 1'b1;
			stall_left--;
		end
		exception_pending = 1'b0;
		pcsel = PC_SEQ;
		target = rand_target(misalign_mode && $urandom % 2 == 0);
		epc = rand_target(misalign_mode && $urandom % 2 == 0);
		if (force_redirect && !stall)
		begin
			pcsel = PC_TARGET;
			target = rand_target(1'b1);
			force_redirect = 1'b0;
		end
		else if (redir_mode && $urandom % 10 == 0)
		begin
			exception_pending = kind[0];	// exception alone or with a pc select
			case (kind[2:1])
				2'b00:   pcsel = PC_SEQ;
				2'b01:   pcsel = PC_RESET;
				2'b10:   pcsel = PC_TARGET;
				default: pcsel = PC_HOLD;
			endcase
		end
		l15_header_ack = rphase == 0 && hdr_cnt == 0;
		l15_ack = (rphase == 1 || l15_header_ack) && ack_cnt == 0;
		ifill_now = rphase == 2 && resp_cnt == 0;
		foreign_now = !ifill_now && foreign_mode && $urandom % 6 == 0;
		l15_resp_val = ifill_now || foreign_now || int_now;
		base = {req_addr[31:4], 4'h0};
		l15_data_0 = {word_at(base), word_at(base + 4)};
		l15_data_1 = {word_at(base + 8), word_at(base + 12)};
		l15_returntype = int_now ? RT_INT : RT_IFILL;
		if (foreign_now)
		begin
			l15_returntype = $urandom % 2 ? RT_LOAD : RT_ST_ACK;
			l15_data_0 = {$urandom, $urandom};
		end
	endtask

	task automatic observe_cycle();
		logic taken;
		addr_t redir;
		taken = !stall && (exception_pending || pcsel == PC_TARGET || pcsel == PC_RESET);
		redir = exception_pending ? epc : (pcsel == PC_TARGET ? target : BOOT_PC);
		if (!woke)
			check_value(l15_val, 1'b0, "request while asleep");
		if (int_now)
		begin
			check_value(l15_req_ack, 1'b1, "interrupt return not acked");
			woke = 1'b1;
		end
		else if (woke && !first_seen && l15_val)
		begin
			check_value(l15_address, BOOT_PC, "first request address");
			first_seen = 1'b1;
		end
		if (l15_val && !val_held)
			check_value(stall, 1'b0, "request started during stall");
		val_held = l15_val && !l15_header_ack;
		case (rphase)
			0:
			begin
				if (l15_val && l15_header_ack)
				begin
					check_value(l15_rqtype, RQ_IFETCH, "l15_rqtype");
					check_value(l15_size, SZ_4B, "l15_size");
					req_addr = l15_address;
					rphase = l15_ack ? 2 : 1;
				end
				else if (l15_val && hdr_cnt > 0)
					hdr_cnt--;
			end
			1:
			begin
				if (l15_ack)
					rphase = 2;
				else
					ack_cnt--;
			end
			default:
			begin
				if (ifill_now)
				begin
					check_value(l15_req_ack, 1'b1, "ifill return not acked");
					rphase = 0;
					hdr_cnt = $urandom % 4;
					ack_cnt = $urandom % 4;
					resp_cnt = $urandom % 4;
				end
				else
					resp_cnt--;
			end
		endcase
		if (foreign_now)
		begin
			check_value(l15_req_ack, 1'b1, "foreign return not acked");
			check_value(instr_valid, 1'b0, "foreign return delivered");
		end
		if (instr_valid)
		begin
			check_value(ifill_now && !stall && !taken, 1'b1, "word delivered at wrong time");
			check_value(pc2, exp_pc, "pc2");
			check_value(instr2, swap_bytes(word_at(exp_pc)), "instr2");
			check_value(addr_misaligned, exp_pc[1:0] == 2'b11, "addr_misaligned");
			if (exp_pc[1:0] == 2'b11)
				misaligned_seen++;
			exp_pc = exp_pc + 4;
			delivered++;
		end
		else
		begin
			check_value(addr_misaligned, 1'b0, "addr_misaligned without delivery");
			if (ifill_now)
				check_value(instr2, NOP_INSTR, "dropped word not a no-op");
		end
		if (taken)
			exp_pc = redir;
	endtask

	task automatic step();
		@(posedge clk);
		#1;
		drive_cycle();
		@(negedge clk);
		observe_cycle();
	endtask

	task automatic run_fetches(input int n);
		int goal;
		goal = delivered + n;
		while (delivered < goal)
			step();
	endtask

	task automatic end_test(input string name, input int err_before);
		$display("%s finished, %0d failed checks", name, errors - err_before);
	endtask

	initial
	begin
		int unsigned seed;
		int err0;
		seed = $urandom(32'h9fe4c046);
		nrst = 1'b0;
		stall = 1'b0;
		pcsel = PC_SEQ;
		target = '0;
		exception_pending = 1'b0;
		epc = '0;
		l15_header_ack = 1'b0;
		l15_ack = 1'b0;
		l15_resp_val = 1'b0;
		l15_data_0 = '0;
		l15_data_1 = '0;
		l15_returntype = RT_IFILL;
		exp_pc = BOOT_PC;
		req_addr = BOOT_PC;
		hdr_cnt = $urandom % 4;
		ack_cnt = $urandom % 4;
		resp_cnt = $urandom % 4;
		repeat (2) @(posedge clk);
		#1 nrst = 1'b1;

		err0 = errors;
		repeat (50) step();	// asleep, no interrupt return yet
		int_now = 1'b1;
		step();
		int_now = 1'b0;
		run_fetches(N_WAKE);
		end_test("sleep and wake", err0);

		err0 = errors;
		run_fetches(N_SEQ);
		end_test("sequential fetch", err0);

		err0 = errors;
		redir_mode = 1'b1;
		run_fetches(N_REDIR);
		redir_mode = 1'b0;
		end_test("redirects", err0);

		err0 = errors;
		stall_mode = 1'b1;
		run_fetches(N_STALL);
		stall_mode = 1'b0;
		end_test("stall", err0);

		err0 = errors;
		misalign_mode = 1'b1;
		foreign_mode = 1'b1;
		force_redirect = 1'b1;
		run_fetches(N_MISC / 3);
		redir_mode = 1'b1;
		run_fetches(N_MISC - N_MISC / 3);
		check_value(misaligned_seen != 0, 1'b1, "no misaligned word delivered");
		end_test("misaligned and foreign returns", err0);

		$display("%0d checks, %0d failed", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: fetch_top.f
fetch_pkg.sv
fetch_pc_gen.sv
fetch_l15_port.sv
fetch_top.sv
fetch_top_properties.sv
tb_fetch_top.sv

// File: Bender.yml
package:
  name: fetch_top

dependencies: {}

sources:
  - fetch_pkg.sv
  - fetch_pc_gen.sv
  - fetch_l15_port.sv
  - fetch_top.sv
  - target: test
    files:
      - fetch_top_properties.sv
      - tb_fetch_top.sv
